/* verilog/sys_io_pkg.sv */
/*
 * System I/O shared definitions
 * Host channel command codes, widths, debounce timing and the
 * packed types passed between the register block, the LED
 * combiner, the audio mixer and the button debouncer.
 */

package sys_io_pkg;

	////////////////////////////////////////////////////////////
	// Host channel
	////////////////////////////////////////////////////////////

	localparam int DATA_W = 16;
	localparam int CMD_W  = 8;

	// Command codes, low byte of the first word
	localparam logic [CMD_W-1:0] CMD_LED = 8'h25;
	localparam logic [CMD_W-1:0] CMD_VOL = 8'h26;

	////////////////////////////////////////////////////////////
	// Buttons
	////////////////////////////////////////////////////////////

	// Clocks between samples, short for simulation
	localparam int DEBOUNCE_TICK = 100;
	localparam int DEBOUNCE_LEN  = 8;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef logic signed [DATA_W-1:0] sample_t;

	// Stereo cross-mix mode, 0 is no mixing
	typedef logic [1:0] mix_t;

	// Bit 4 mutes, bits 3:0 are the shift count
	typedef logic [4:0] att_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_cfg_t;

	// Power is {override, value}
	typedef struct packed {
		logic       user;
		logic       disk;
		logic [1:0] power;
	} core_leds_t;

	typedef struct packed {
		logic user;
		logic osd;
	} btn_state_t;

endpackage

/* verilog/hps_cmd_regs.sv */
/*
 * Host command register block
 * Decodes strobed words from the host channel. The first word
 * after select is the command, later words are its data. Holds
 * the LED overtake/state bytes and the volume attenuation.
 */

`timescale 1ns/1ns

module hps_cmd_regs (
	input  logic                          clk,
	input  logic                          resetd,
	input  logic                          i_io_uio,
	input  logic                          i_io_strobe,
	input  logic [sys_io_pkg::DATA_W-1:0] i_io_din,
	output sys_io_pkg::led_cfg_t          o_led_cfg,
	output sys_io_pkg::att_t              o_vol_att
);

	logic                          uio_q;
	logic                          strobe_q;
	logic                          strobe_prev;
	logic [sys_io_pkg::DATA_W-1:0] din_q;
	logic                          strobe_rise;
	logic                          has_cmd;
	logic [sys_io_pkg::CMD_W-1:0]  cmd;

	////////////////////////////////////////////////////////////
	// Input capture and edge detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			uio_q       <= 1'b0;
			strobe_q    <= 1'b0;
			strobe_prev <= 1'b0;
		end else begin
			uio_q       <= i_io_uio;
			strobe_q    <= i_io_strobe;
			strobe_prev <= strobe_q;
		end
	end

	// Data word travels with its strobe
	always_ff @(posedge clk) begin
		din_q <= i_io_din;
	end

	assign strobe_rise = strobe_q & ~strobe_prev;

	////////////////////////////////////////////////////////////
	// Command decode and register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= '0;
			o_led_cfg <= '0;
			o_vol_att <= '0;
		end else if (!uio_q) begin
			// Deselect forgets the command
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_q[sys_io_pkg::CMD_W-1:0];
			end else begin
				case (cmd)
					sys_io_pkg::CMD_LED: o_led_cfg <= din_q;
					sys_io_pkg::CMD_VOL: o_vol_att <= din_q[4:0];
					default: ;
				endcase
			end
		end
	end

	// Settings only move under a command latched on an earlier word
	a_write_needs_cmd: assert property (
		@(posedge clk) disable iff (resetd)
		($changed(o_led_cfg) || $changed(o_vol_att)) |-> $past(has_cmd)
	);

endmodule

/* verilog/button_debounce.sv */
/*
 * Button debouncer
 * Samples the user and OSD keys on a slow tick into shift
 * windows. A flag sets on a full window and clears on an empty one.
 */

`timescale 1ns/1ns

module button_debounce (
	input  logic                   clk,
	input  logic                   resetd,
	input  logic                   i_key_user_n,
	input  logic                   i_key_osd_n,
	input  logic                   i_core_osd,
	output sys_io_pkg::btn_state_t o_buttons
);

	localparam int TICK_W = $clog2(sys_io_pkg::DEBOUNCE_TICK);

	logic [TICK_W-1:0]                   tick_cnt;
	logic                                tick;
	logic [1:0]                          pressed;
	logic [sys_io_pkg::DEBOUNCE_LEN-1:0] win [2];
	logic [1:0]                          flag;

	// Tick divider
	always_ff @(posedge clk) begin
		if (resetd || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == TICK_W'(sys_io_pkg::DEBOUNCE_TICK - 1));

	// Keys are active low, core can also request OSD
	always_ff @(posedge clk) begin
		if (resetd) begin
			pressed <= '0;
		end else begin
			pressed[1] <= ~i_key_user_n;
			pressed[0] <= ~i_key_osd_n | i_core_osd;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			win[0] <= '0;
			win[1] <= '0;
			flag   <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				win[i] <= {win[i][sys_io_pkg::DEBOUNCE_LEN-2:0], pressed[i]};
				if (&win[i])
					flag[i] <= 1'b1;
				if (~|win[i])
					flag[i] <= 1'b0;
			end
		end
	end

	assign o_buttons.user = flag[1];
	assign o_buttons.osd  = flag[0];

	a_tick_in_range: assert property (
		@(posedge clk) disable iff (resetd)
		tick_cnt < TICK_W'(sys_io_pkg::DEBOUNCE_TICK)
	);

endmodule

/* verilog/status_leds.sv */
/*
 * Board LED combiner
 * Builds the default pattern from core LED requests and lets
 * the host take over any bit with its overtake/state bytes.
 */

`timescale 1ns/1ns

module status_leds (
	input  logic                   clk,
	input  logic                   resetd,
	input  sys_io_pkg::core_leds_t i_core_leds,
	input  sys_io_pkg::led_cfg_t   i_led_cfg,
	output logic [7:0]             o_led
);

	logic       led_pwr;
	logic [7:0] dflt;

	// Power is on unless overridden off
	assign led_pwr = ~i_core_leds.power[1] | i_core_leds.power[0];

	// Bit 6 was the PLL lock, reads zero here
	assign dflt = {3'b000, led_pwr, 1'b0, i_core_leds.disk, 1'b0, i_core_leds.user};

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_led <= '0;
		end else begin
			o_led <= (i_led_cfg.overtake & i_led_cfg.state) |
			         (~i_led_cfg.overtake & dflt);
		end
	end

endmodule

/* verilog/audio_mix_channel.sv */
/*
 * Audio mixer channel
 * Settles the core sample, adds host audio, applies stereo
 * cross-mix with the other channel, attenuates and clamps.
 */

`timescale 1ns/1ns

module audio_mix_channel (
	input  logic                clk,
	input  logic                resetd,
	input  sys_io_pkg::sample_t i_core,
	input  sys_io_pkg::sample_t i_host,
	input  sys_io_pkg::sample_t i_pre,
	input  sys_io_pkg::mix_t    i_mix,
	input  logic                i_is_signed,
	input  sys_io_pkg::att_t    i_att,
	output sys_io_pkg::sample_t o_pre,
	output sys_io_pkg::sample_t o_out
);

	sys_io_pkg::sample_t d1;
	sys_io_pkg::sample_t d2;
	sys_io_pkg::sample_t d3;
	sys_io_pkg::sample_t ca;
	logic signed [16:0]  a1;
	logic signed [16:0]  a2;
	logic signed [16:0]  a3;
	logic signed [16:0]  a4;

	////////////////////////////////////////////////////////////
	// Settle filter
	////////////////////////////////////////////////////////////

	// Only take a sample that held steady, drops glitchy updates
	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3)
				ca <= d2;
		end
	end

	////////////////////////////////////////////////////////////
	// Sum, cross-mix, attenuate, clamp
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned samples are halved to fit the signed range
			a1 <= i_is_signed ? {ca[15], ca} : {2'b00, ca[15:1]};
			a2 <= a1 + {i_host[15], i_host};

			o_pre <= a2[16:1];

			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (i_pre >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (i_pre >>> 1);
				2'd3: a3 <= (a2 >>> 1) + i_pre;
			endcase

			if (i_att[4])
				a4 <= '0;
			else
				a4 <= a3 >>> i_att[3:0];

			// Saturate when bits 16 and 15 disagree
			if (a4[16] != a4[15])
				o_out <= {a4[16], {15{a4[15]}}};
			else
				o_out <= a4[15:0];
		end
	end

	a_mute_silences: assert property (
		@(posedge clk) disable iff (resetd)
		i_att[4] [*3] |-> (o_out == '0)
	);

endmodule

/* verilog/sys_io_top.sv */
/*
 * System I/O top level
 * Host command registers beside the board LED combiner, the
 * stereo audio mixer and the button debouncer.
 */

`timescale 1ns/1ns

module sys_io_top (
	input  logic                          clk,
	input  logic                          resetd,
	input  logic                          i_io_uio,
	input  logic                          i_io_strobe,
	input  logic [sys_io_pkg::DATA_W-1:0] i_io_din,
	input  sys_io_pkg::core_leds_t        i_core_leds,
	input  logic                          i_key_user_n,
	input  logic                          i_key_osd_n,
	input  logic                          i_core_osd,
	input  sys_io_pkg::sample_t           i_core_l,
	input  sys_io_pkg::sample_t           i_core_r,
	input  sys_io_pkg::sample_t           i_host_l,
	input  sys_io_pkg::sample_t           i_host_r,
	input  sys_io_pkg::mix_t              i_mix,
	input  logic                          i_is_signed,
	output logic [7:0]                    o_led,
	output sys_io_pkg::btn_state_t        o_buttons,
	output sys_io_pkg::sample_t           o_audio_l,
	output sys_io_pkg::sample_t           o_audio_r
);

	sys_io_pkg::led_cfg_t led_cfg;
	sys_io_pkg::att_t     vol_att;
	sys_io_pkg::sample_t  pre_l;
	sys_io_pkg::sample_t  pre_r;

	hps_cmd_regs u_hps_cmd_regs (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_led_cfg   (led_cfg),
		.o_vol_att   (vol_att)
	);

	status_leds u_status_leds (
		.clk         (clk),
		.resetd      (resetd),
		.i_core_leds (i_core_leds),
		.i_led_cfg   (led_cfg),
		.o_led       (o_led)
	);

	button_debounce u_button_debounce (
		.clk          (clk),
		.resetd       (resetd),
		.i_key_user_n (i_key_user_n),
		.i_key_osd_n  (i_key_osd_n),
		.i_core_osd   (i_core_osd),
		.o_buttons    (o_buttons)
	);

	////////////////////////////////////////////////////////////
	// Audio, pre values cross over between channels
	////////////////////////////////////////////////////////////

	audio_mix_channel u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_core_l),
		.i_host      (i_host_l),
		.i_pre       (pre_r),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_att       (vol_att),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_channel u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_core      (i_core_r),
		.i_host      (i_host_r),
		.i_pre       (pre_l),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_att       (vol_att),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

endmodule

/* tests/tb_sys_io_top.sv */
/*
 * Testbench for the system I/O top level
 * Drives the host channel, core LED requests, audio and keys,
 * and checks every output against reference models.
 */

`timescale 1ns/1ns

module tb_sys_io_top;

	localparam int SETTLE   = 20;
	localparam int N_RAND   = 12;
	localparam int CMD_CYC  = 40;
	localparam int STEP     = CMD_CYC + 2 * (SETTLE + 1);
	localparam int BTN_WAIT = (sys_io_pkg::DEBOUNCE_LEN + 2) * sys_io_pkg::DEBOUNCE_TICK;
	localparam int WINDOW   = sys_io_pkg::DEBOUNCE_LEN * sys_io_pkg::DEBOUNCE_TICK;
	// Reset, LED tests, audio test, mute test, button test, then 20 windows
	localparam int WATCHDOG_CYCLES = 5 + 2 * N_RAND * STEP + N_RAND * STEP + 4 * STEP +
	                                 8 * BTN_WAIT + 20 * WINDOW;

	logic                          clk = 1'b0;
	logic                          resetd;
	logic                          i_io_uio;
	logic                          i_io_strobe;
	logic [sys_io_pkg::DATA_W-1:0] i_io_din;
	sys_io_pkg::core_leds_t        i_core_leds;
	logic                          i_key_user_n;
	logic                          i_key_osd_n;
	logic                          i_core_osd;
	sys_io_pkg::sample_t           i_core_l;
	sys_io_pkg::sample_t           i_core_r;
	sys_io_pkg::sample_t           i_host_l;
	sys_io_pkg::sample_t           i_host_r;
	sys_io_pkg::mix_t              i_mix;
	logic                          i_is_signed;
	logic [7:0]                    o_led;
	sys_io_pkg::btn_state_t        o_buttons;
	sys_io_pkg::sample_t           o_audio_l;
	sys_io_pkg::sample_t           o_audio_r;

	// Model of the host settings and expected key flags
	sys_io_pkg::led_cfg_t   mdl_cfg;
	sys_io_pkg::att_t       mdl_att;
	sys_io_pkg::btn_state_t exp_btn;

	integer seed = 32'h96b3fe4e;
	int     led_errors = 0;
	int     sample_errors = 0;
	int     btn_errors = 0;
	string  test_name = "";
	event   do_compare;

	always #50 clk = ~clk;

	sys_io_top u_sys_io_top (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_core_leds  (i_core_leds),
		.i_key_user_n (i_key_user_n),
		.i_key_osd_n  (i_key_osd_n),
		.i_core_osd   (i_core_osd),
		.i_core_l     (i_core_l),
		.i_core_r     (i_core_r),
		.i_host_l     (i_host_l),
		.i_host_r     (i_host_r),
		.i_mix        (i_mix),
		.i_is_signed  (i_is_signed),
		.o_led        (o_led),
		.o_buttons    (o_buttons),
		.o_audio_l    (o_audio_l),
		.o_audio_r    (o_audio_r)
	);

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////

	function automatic logic [7:0] led_pattern(input sys_io_pkg::core_leds_t core,
	                                           input sys_io_pkg::led_cfg_t cfg);
		logic [7:0] dflt;
		dflt    = 8'h00;
		dflt[0] = core.user;
		dflt[2] = core.disk;
		dflt[4] = !core.power[1] || core.power[0];
		return (cfg.overtake & cfg.state) | (~cfg.overtake & dflt);
	endfunction

	// One channel's sum cross-mixed with half the other channel's sum
	function automatic int cross_mix(input sys_io_pkg::sample_t core,
	                                 input sys_io_pkg::sample_t host,
	                                 input sys_io_pkg::sample_t core_o,
	                                 input sys_io_pkg::sample_t host_o,
	                                 input sys_io_pkg::mix_t mode, input logic sgn);
		int sum;
		int sum_o;
		int pre_o;
		sum   = (sgn ? int'(core) : int'({1'b0, core[15:1]})) + int'(host);
		sum_o = (sgn ? int'(core_o) : int'({1'b0, core_o[15:1]})) + int'(host_o);
		pre_o = sum_o >>> 1;
		case (mode)
			2'd0: return sum;
			2'd1: return sum - (sum >>> 3) + (pre_o >>> 2);
			2'd2: return sum - (sum >>> 2) + (pre_o >>> 1);
			default: return (sum >>> 1) + pre_o;
		endcase
	endfunction

	function automatic sys_io_pkg::sample_t attenuate(input int value, input sys_io_pkg::att_t att);
		int v;
		if (att[4])
			return '0;
		v = value >>> att[3:0];
		if (v > 32767)
			v = 32767;
		if (v < -32768)
			v = -32768;
		return sys_io_pkg::sample_t'(v);
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks and process
	////////////////////////////////////////////////////////////

	task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			led_errors++;
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input sys_io_pkg::sample_t exp,
	                            input sys_io_pkg::sample_t act);
		if (act !== exp) begin
			sample_errors++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_buttons(input string name, input sys_io_pkg::btn_state_t exp,
	                             input sys_io_pkg::btn_state_t act);
		if (act !== exp) begin
			btn_errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	always begin : compare
		sys_io_pkg::sample_t exp_l;
		sys_io_pkg::sample_t exp_r;
		@(do_compare);
		exp_l = attenuate(cross_mix(i_core_l, i_host_l, i_core_r, i_host_r, i_mix, i_is_signed),
		                  mdl_att);
		exp_r = attenuate(cross_mix(i_core_r, i_host_r, i_core_l, i_host_l, i_mix, i_is_signed),
		                  mdl_att);
		check_led(test_name, led_pattern(i_core_leds, mdl_cfg), o_led);
		check_sample({test_name, " left"}, exp_l, o_audio_l);
		check_sample({test_name, " right"}, exp_r, o_audio_r);
		check_buttons(test_name, exp_btn, o_buttons);
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Outputs are stable on the falling edge
	task automatic compare_now(input string name);
		@(negedge clk);
		test_name = name;
		-> do_compare;
	endtask

	task automatic settle_and_compare(input string name);
		repeat (SETTLE) @(posedge clk);
		compare_now(name);
	endtask

	task automatic select_channel(input logic on);
		@(posedge clk);
		i_io_uio <= on;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_word(input logic [15:0] word);
		@(posedge clk);
		i_io_din    <= word;
		i_io_strobe <= 1'b1;
		repeat (2) @(posedge clk);
		i_io_strobe <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_command(input logic [7:0] code, input logic [15:0] data);
		select_channel(1'b1);
		send_word({8'h00, code});
		send_word(data);
		select_channel(1'b0);
	endtask

	task automatic drive_random_audio();
		@(posedge clk);
		i_core_l    <= $random(seed);
		i_core_r    <= $random(seed);
		i_host_l    <= $random(seed);
		i_host_r    <= $random(seed);
		i_mix       <= $random(seed);
		i_is_signed <= $random(seed);
	endtask

	task automatic wait_buttons(input int max_cycles);
		int n;
		n = 0;
		while (o_buttons !== exp_btn && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] rnd;
		logic [7:0]  code;
		int          total;
		resetd       = 1'b1;
		i_io_uio     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_core_leds  = '0;
		i_key_user_n = 1'b1;
		i_key_osd_n  = 1'b1;
		i_core_osd   = 1'b0;
		i_core_l     = '0;
		i_core_r     = '0;
		i_host_l     = '0;
		i_host_r     = '0;
		i_mix        = '0;
		i_is_signed  = 1'b0;
		mdl_cfg      = '0;
		mdl_att      = '0;
		exp_btn      = '0;
		repeat (5) @(posedge clk);
		resetd <= 1'b0;

		// Default pattern before any host override
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			drive_random_audio();
			i_core_leds <= rnd[3:0];
			settle_and_compare("default leds");
		end

		// Host takes over LED bits and a later word replaces the first
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			select_channel(1'b1);
			i_core_leds <= rnd[19:16];
			send_word({8'h00, sys_io_pkg::CMD_LED});
			send_word(rnd[15:0]);
			mdl_cfg = rnd[15:0];
			settle_and_compare("led overtake");
			rnd = $random(seed);
			send_word(rnd[15:0]);
			mdl_cfg = rnd[15:0];
			settle_and_compare("led replace");
			select_channel(1'b0);
		end

		// Volume with random samples, modes and signedness
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			send_command(sys_io_pkg::CMD_VOL, {rnd[15:5], 1'b0, rnd[3:0]});
			mdl_att = {1'b0, rnd[3:0]};
			drive_random_audio();
			settle_and_compare("volume mix");
		end

		// Mute followed by words that must not change anything
		rnd = $random(seed);
		send_command(sys_io_pkg::CMD_VOL, {rnd[15:5], 1'b1, rnd[3:0]});
		mdl_att = {1'b1, rnd[3:0]};
		drive_random_audio();
		settle_and_compare("mute");
		send_word({8'h00, sys_io_pkg::CMD_VOL});
		send_word(16'h0000);
		settle_and_compare("deselected volume");
		send_word({8'h00, sys_io_pkg::CMD_LED});
		send_word(~mdl_cfg);
		settle_and_compare("deselected leds");
		do begin
			rnd  = $random(seed);
			code = rnd[7:0];
		end while (code == sys_io_pkg::CMD_LED || code == sys_io_pkg::CMD_VOL);
		send_command(code, 16'h0000);
		settle_and_compare("unknown command");

		// User key press, one-tick glitch, release
		@(posedge clk);
		i_key_user_n <= 1'b0;
		exp_btn.user = 1'b1;
		wait_buttons(BTN_WAIT);
		compare_now("user press");
		@(posedge clk);
		i_key_user_n <= 1'b1;
		repeat (sys_io_pkg::DEBOUNCE_TICK) @(posedge clk);
		i_key_user_n <= 1'b0;
		for (int j = 0; j < sys_io_pkg::DEBOUNCE_LEN + 2; j++) begin
			repeat (sys_io_pkg::DEBOUNCE_TICK) @(posedge clk);
			compare_now("user glitch");
		end
		@(posedge clk);
		i_key_user_n <= 1'b1;
		exp_btn.user = 1'b0;
		wait_buttons(BTN_WAIT);
		compare_now("user release");

		// OSD key followed by the core OSD request
		@(posedge clk);
		i_key_osd_n <= 1'b0;
		exp_btn.osd = 1'b1;
		wait_buttons(BTN_WAIT);
		compare_now("osd press");
		@(posedge clk);
		i_key_osd_n <= 1'b1;
		exp_btn.osd = 1'b0;
		wait_buttons(BTN_WAIT);
		compare_now("osd release");
		@(posedge clk);
		i_core_osd <= 1'b1;
		exp_btn.osd = 1'b1;
		wait_buttons(BTN_WAIT);
		compare_now("core osd set");
		@(posedge clk);
		i_core_osd <= 1'b0;
		exp_btn.osd = 1'b0;
		wait_buttons(BTN_WAIT);
		compare_now("core osd clear");

		repeat (2) @(posedge clk);
		total = led_errors + sample_errors + btn_errors;
		$display("Errors: %0d (led %0d, audio %0d, buttons %0d)",
		         total, led_errors, sample_errors, btn_errors);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Errors: %0d (led %0d, audio %0d, buttons %0d)",
		         led_errors + sample_errors + btn_errors + 1,
		         led_errors, sample_errors, btn_errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sources.f */
verilog/sys_io_pkg.sv
verilog/hps_cmd_regs.sv
verilog/button_debounce.sv
verilog/status_leds.sv
verilog/audio_mix_channel.sv
verilog/sys_io_top.sv
tests/tb_sys_io_top.sv

/* Bender.yml */
package:
  name: sys_io

sources:
  - verilog/sys_io_pkg.sv
  - verilog/hps_cmd_regs.sv
  - verilog/button_debounce.sv
  - verilog/status_leds.sv
  - verilog/audio_mix_channel.sv
  - verilog/sys_io_top.sv
  - target: simulation
    files:
      - tests/tb_sys_io_top.sv
